// File: bench/leaf_checker.sv
module leaf_checker import bft_pkg::*, leaf_cfg_pkg::*; (
    input logic                   clk,
    input logic                   reset,
    input logic                   resend,
    input logic                   psel,
    input logic                   penable,
    input logic                   pready,
    input logic                   pslverr,
    input logic [packet_bits-1:0] dout,
    input logic [dest_bits-1:0]   dest_1,
    input logic [dest_bits-1:0]   dest_2,
    input logic [dest_bits-1:0]   dest_3,
    input logic [dest_bits-1:0]   dest_4
);

    bft_packet_t          pkt;
    logic [dest_bits-1:0] pkt_dest;
    int unsigned          n_pready = 0;
    int unsigned          n_resend = 0;
    int unsigned          n_reset  = 0;
    int unsigned          n_slverr = 0;
    int unsigned          n_dest   = 0;
    int unsigned          fail_total;

    assign pkt        = dout;
    assign pkt_dest   = {pkt.leaf, pkt.port};
    assign fail_total = n_pready + n_resend + n_reset + n_slverr + n_dest;    // read by tb

    // ##############################
    // apb side
    // ##############################
    pready_high: assert property (@(posedge clk) disable iff (reset) pready)
        else begin
            $error("pready went low");
            n_pready++;
        end

    slverr_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable))
        else begin
            $error("pslverr outside an access phase");
            n_slverr++;
        end

    reset_idle: assert property (@(posedge clk) $fell(reset) |-> (dout == '0) && !pslverr)
        else begin
            $error("dout or pslverr not idle after reset");
            n_reset++;
        end

    // ##############################
    // tree output side
    // ##############################
    resend_blank: assert property (@(posedge clk) disable iff (reset) resend |-> (dout == '0))
        else begin
            $error("dout not blank during resend");
            n_resend++;
        end

    dest_known: assert property (@(posedge clk) disable iff (reset)
        pkt.valid |-> (pkt_dest == dest_1) || (pkt_dest == dest_2)
                   || (pkt_dest == dest_3) || (pkt_dest == dest_4))
        else begin
            $error("dout destination matches no dest register");
            n_dest++;
        end

endmodule

bind leaf_i1o4 leaf_checker chk (
    .clk, .reset, .resend, .psel, .penable, .pready, .pslverr,
    .dout(dout_leaf_interface2bft),
    .dest_1, .dest_2, .dest_3, .dest_4
);

// File: bench/tb_leaf.sv
module tb_leaf import bft_pkg::*, leaf_cfg_pkg::*; ();

    localparam int                   max_cycles = 3000;
    localparam logic [leaf_bits-1:0] own_leaf   = 5'd9;
    localparam logic [port_bits-1:0] own_port   = port_bits'(in_port_id);
    localparam logic [dest_bits-1:0] dest_val [4] = '{9'h032, 9'h0A3, 9'h114, 9'h1F5};

    logic                     clk;
    logic                     reset;
    bft_packet_t              din;
    logic [packet_bits-1:0]   dout;
    logic                     resend;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_addr_bits-1:0] paddr;
    logic [apb_data_bits-1:0] pwdata;
    logic [apb_data_bits-1:0] prdata;
    logic                     pready;
    logic                     pslverr;

    bft_packet_t          exp_q [4][$];    // per output port
    payload_t             model_sum = '0;
    logic [addr_bits-1:0] model_idx = '0;
    int                   data_errs = 0;
    int                   reg_errs  = 0;
    int                   cycle_cnt = 0;

    leaf_i1o4 dut (
        .clk, .reset, .din_leaf_bft2interface(din), .dout_leaf_interface2bft(dout), .resend,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = data_errs + reg_errs + int'(dut.chk.fail_total);
        $display("errors: data %0d, register %0d, assertion %0d",
                 data_errs, reg_errs, dut.chk.fail_total);
        if (total == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ##############################
    // apb access
    // ##############################
    task automatic apb_access(input logic wr, input logic [apb_addr_bits-1:0] addr,
                              input logic [apb_data_bits-1:0] wdata,
                              output logic [apb_data_bits-1:0] rdata, output logic err);
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        step();
        penable = 1'b1;
        #40;    // mid access phase
        rdata = prdata;
        err   = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_bits-1:0] addr, input int data);
        logic [apb_data_bits-1:0] rdata;
        logic                     err;
        apb_access(1'b1, addr, data, rdata, err);
        if (err) begin
            reg_errs++;
            $display("write to register %h was refused with pslverr", addr);
        end
    endtask

    task automatic apb_read(input logic [apb_addr_bits-1:0] addr, input int expected);
        logic [apb_data_bits-1:0] rdata;
        logic                     err;
        apb_access(1'b0, addr, '0, rdata, err);
        if (err) begin
            reg_errs++;
            $display("FAILED %0t pslverr on read of %h expected 0 actual 1", $time, addr);
        end else if (rdata !== expected) begin
            reg_errs++;
            $display("FAILED %0t prdata at %h expected %h actual %h",
                     $time, addr, expected, rdata);
        end
    endtask

    task automatic expect_slverr(input logic wr, input logic [apb_addr_bits-1:0] addr);
        logic [apb_data_bits-1:0] rdata;
        logic                     err;
        apb_access(wr, addr, 32'hffff_ffff, rdata, err);
        if (!err) begin
            reg_errs++;
            $display("access to offset %h completed without pslverr", addr);
        end
    endtask

    // ##############################
    // packets and scoreboard
    // ##############################
    task automatic send_packet(input logic [leaf_bits-1:0] leaf, input logic [port_bits-1:0] port,
                               input payload_t payload, input int gap);
        step();
        din = {1'b1, leaf, port, 7'd0, payload};
        step();
        din = '0;
        repeat (gap - 1) step();
    endtask

    function automatic void expect_word(input payload_t x);
        payload_t res [4];
        model_sum = model_sum + x;
        res[0] = x;
        res[1] = x << 1;
        res[2] = ~x;
        res[3] = model_sum;    // running sum with x
        for (int k = 0; k < 4; k++) begin
            exp_q[k].push_back(bft_packet_t'({1'b1, dest_val[k], model_idx, res[k]}));
        end
        model_idx = model_idx + 1'b1;
    endfunction

    function automatic int pending();
        return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
    endfunction

    task automatic wait_drain();
        while (pending() != 0) step();
    endtask

    always @(negedge clk) begin : monitor
        bft_packet_t got;
        bft_packet_t want;
        int          k;
        got = dout;
        if (!reset && got.valid) begin
            k = -1;
            for (int i = 0; i < 4; i++) begin
                if ({got.leaf, got.port} == dest_val[i]) k = i;
            end
            if (k < 0) begin
                data_errs++;
                $display("packet at %0t has an unknown destination: %h", $time, got);
            end else if (exp_q[k].size() == 0) begin
                data_errs++;
                $display("unexpected packet at %0t for output port %0d: %h", $time, k + 1, got);
            end else begin
                want = exp_q[k].pop_front();
                if (got !== want) begin
                    data_errs++;
                    $display("FAILED %0t dout_leaf_interface2bft expected %h actual %h",
                             $time, want, got);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == max_cycles) begin
            $display("timeout after %0d cycles, the tests did not complete", max_cycles);
            finish_run(1'b1);
        end
    end

    // ##############################
    // tests
    // ##############################
    task automatic register_readback();
        apb_write(reg_leaf_id, own_leaf);
        apb_write(reg_dest_1, dest_val[0]);
        apb_write(reg_dest_2, dest_val[1]);
        apb_write(reg_dest_3, dest_val[2]);
        apb_write(reg_dest_4, dest_val[3]);
        apb_write(reg_ctrl, 1);
        apb_read(reg_leaf_id, own_leaf);
        apb_read(reg_dest_1, dest_val[0]);
        apb_read(reg_dest_2, dest_val[1]);
        apb_read(reg_dest_3, dest_val[2]);
        apb_read(reg_dest_4, dest_val[3]);
        apb_read(reg_ctrl, 1);
        expect_slverr(1'b0, 8'h20);
        expect_slverr(1'b1, reg_drop_cnt);
        apb_read(reg_drop_cnt, 0);    // refused write left it alone
    endtask

    task automatic kernel_results();
        payload_t x;
        for (int i = 0; i < 20; i++) begin
            x = $urandom();
            expect_word(x);
            send_packet(own_leaf, own_port, x, 5);    // paced to the encoder rate
        end
        wait_drain();
        apb_read(reg_drop_cnt, 0);
    endtask

    task automatic misroute_discard();
        for (int i = 0; i < 3; i++) send_packet(own_leaf + 1'b1, own_port, $urandom(), 1);
        for (int i = 0; i < 2; i++) send_packet(own_leaf, 4'd0, $urandom(), 1);
        repeat (4) step();    // nothing may come out
        apb_read(reg_misroute_cnt, 5);
    endtask

    task automatic stall_and_drop();
        payload_t x;
        apb_write(reg_ctrl, 0);
        for (int i = 0; i < 12; i++) begin
            x = $urandom();
            if (i < 8) expect_word(x);    // the rest find in_q full
            send_packet(own_leaf, own_port, x, 1);
        end
        apb_read(reg_drop_cnt, 4);
        apb_write(reg_ctrl, 1);
        wait_drain();
    endtask

    task automatic resend_hold();
        payload_t x;
        for (int i = 0; i < 6; i++) begin
            x = $urandom();
            expect_word(x);
            send_packet(own_leaf, own_port, x, 1);
        end
        step();
        resend = 1'b1;
        repeat (10) step();
        resend = 1'b0;
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h2a84_0c3a));
        reset   = 1'b1;
        din     = '0;
        resend  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        register_readback();
        kernel_results();
        misroute_discard();
        stall_and_drop();
        resend_hold();
        finish_run(1'b0);
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_leaf -f sim.f -o tb_leaf
./obj_dir/tb_leaf +verilator+error+limit+100 | tee sim.log

grep -q "Regression passed" sim.log

// File: sim.f
verilog/bft_pkg.sv
verilog/leaf_cfg_pkg.sv
verilog/stream_fifo.sv
verilog/packet_decoder.sv
verilog/user_kernel.sv
verilog/packet_encoder.sv
verilog/leaf_config_apb.sv
verilog/leaf_i1o4.sv
bench/leaf_checker.sv
bench/tb_leaf.sv

// File: verilog/bft_pkg.sv
package bft_pkg;

    // ##############################
    // packet fields, top bit first
    // ##############################
    localparam int packet_bits  = 49;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;
    localparam int payload_bits = 32;

    localparam int num_out_ports = 4;
    localparam int in_port_id    = 1;    // the single input port
    localparam int queue_depth   = 8;

    typedef logic [payload_bits-1:0] payload_t;

    typedef struct packed {
        logic                 valid;
        logic [leaf_bits-1:0] leaf;    // destination leaf
        logic [port_bits-1:0] port;    // destination port
        logic [addr_bits-1:0] addr;    // word index
        payload_t             payload;
    } bft_packet_t;

    // output queue entry, dest is added by the encoder
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        payload_t             payload;
    } out_item_t;

endpackage

// File: verilog/leaf_cfg_pkg.sv
package leaf_cfg_pkg;

    localparam int apb_addr_bits = 8;
    localparam int apb_data_bits = 32;

    // ##############################
    // register map
    // ##############################
    localparam logic [apb_addr_bits-1:0] reg_ctrl         = 8'h00;    // bit 0 enable
    localparam logic [apb_addr_bits-1:0] reg_leaf_id      = 8'h04;
    localparam logic [apb_addr_bits-1:0] reg_dest_1       = 8'h08;
    localparam logic [apb_addr_bits-1:0] reg_dest_2       = 8'h0C;
    localparam logic [apb_addr_bits-1:0] reg_dest_3       = 8'h10;
    localparam logic [apb_addr_bits-1:0] reg_dest_4       = 8'h14;
    localparam logic [apb_addr_bits-1:0] reg_drop_cnt     = 8'h18;    // read only
    localparam logic [apb_addr_bits-1:0] reg_misroute_cnt = 8'h1C;    // read only

    // field widths
    localparam int leaf_id_bits = bft_pkg::leaf_bits;
    localparam int dest_bits    = bft_pkg::leaf_bits + bft_pkg::port_bits;    // leaf then port
    localparam int cnt_bits     = 16;

endpackage

// File: verilog/leaf_config_apb.sv
module leaf_config_apb import leaf_cfg_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [apb_addr_bits-1:0] paddr,
    input  logic [apb_data_bits-1:0] pwdata,
    output logic [apb_data_bits-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     drop,
    input  logic                     misroute,
    output logic                     enable,
    output logic [leaf_id_bits-1:0]  leaf_id,
    output logic [dest_bits-1:0]     dest_1,
    output logic [dest_bits-1:0]     dest_2,
    output logic [dest_bits-1:0]     dest_3,
    output logic [dest_bits-1:0]     dest_4
);

    logic                access;
    logic                hit;
    logic                read_only;
    logic                wr_en;
    logic [cnt_bits-1:0] drop_cnt;
    logic [cnt_bits-1:0] misroute_cnt;

    assign access  = psel && penable;
    assign pready  = 1'b1;    // zero wait states
    assign pslverr = access && (!hit || (pwrite && read_only));
    assign wr_en   = access && pwrite && !pslverr;

    // ##############################
    // address decode and read mux
    // ##############################
    always_comb begin
        hit       = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            reg_ctrl:    prdata = apb_data_bits'(enable);
            reg_leaf_id: prdata = apb_data_bits'(leaf_id);
            reg_dest_1:  prdata = apb_data_bits'(dest_1);
            reg_dest_2:  prdata = apb_data_bits'(dest_2);
            reg_dest_3:  prdata = apb_data_bits'(dest_3);
            reg_dest_4:  prdata = apb_data_bits'(dest_4);
            reg_drop_cnt: begin
                prdata    = apb_data_bits'(drop_cnt);
                read_only = 1'b1;
            end
            reg_misroute_cnt: begin
                prdata    = apb_data_bits'(misroute_cnt);
                read_only = 1'b1;
            end
            default:     hit = 1'b0;
        endcase
    end

    // ##############################
    // registers and counters
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            enable       <= 1'b0;
            leaf_id      <= '0;
            dest_1       <= '0;
            dest_2       <= '0;
            dest_3       <= '0;
            dest_4       <= '0;
            drop_cnt     <= '0;
            misroute_cnt <= '0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    reg_ctrl:    enable  <= pwdata[0];
                    reg_leaf_id: leaf_id <= pwdata[leaf_id_bits-1:0];
                    reg_dest_1:  dest_1  <= pwdata[dest_bits-1:0];
                    reg_dest_2:  dest_2  <= pwdata[dest_bits-1:0];
                    reg_dest_3:  dest_3  <= pwdata[dest_bits-1:0];
                    reg_dest_4:  dest_4  <= pwdata[dest_bits-1:0];
                    default:     enable  <= enable;
                endcase
            end
            if (drop && drop_cnt != '1) drop_cnt <= drop_cnt + 1'b1;    // saturating
            if (misroute && misroute_cnt != '1) misroute_cnt <= misroute_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/leaf_i1o4.sv
module leaf_i1o4 import bft_pkg::*, leaf_cfg_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [packet_bits-1:0]   din_leaf_bft2interface,
    output logic [packet_bits-1:0]   dout_leaf_interface2bft,
    input  logic                     resend,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [apb_addr_bits-1:0] paddr,
    input  logic [apb_data_bits-1:0] pwdata,
    output logic [apb_data_bits-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr
);

    logic                     enable;
    logic [leaf_id_bits-1:0]  leaf_id;
    logic [dest_bits-1:0]     dest_1, dest_2, dest_3, dest_4;
    logic                     drop, misroute;
    logic                     in_push, in_full, in_pop, in_empty;
    payload_t                 in_push_item, in_pop_item;
    logic [num_out_ports-1:0] out_push, out_full, out_pop, out_empty;
    out_item_t                kern_item_1, kern_item_2, kern_item_3, kern_item_4;
    out_item_t                enc_item_1, enc_item_2, enc_item_3, enc_item_4;

    // ##############################
    // configuration
    // ##############################
    leaf_config_apb cfg (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .drop, .misroute, .enable, .leaf_id, .dest_1, .dest_2, .dest_3, .dest_4
    );

    // ##############################
    // decode
    // ##############################
    packet_decoder decode (
        .clk, .reset, .din(din_leaf_bft2interface), .leaf_id,
        .push(in_push), .push_item(in_push_item), .full(in_full), .drop, .misroute
    );

    stream_fifo #(.item_t(payload_t)) in_q (
        .clk, .reset, .push(in_push), .push_item(in_push_item), .full(in_full),
        .pop(in_pop), .pop_item(in_pop_item), .empty(in_empty)
    );

    // ##############################
    // execute
    // ##############################
    user_kernel execute (
        .clk, .reset, .enable, .in_empty, .in_item(in_pop_item), .in_pop,
        .out_full, .out_push, .out_item_1(kern_item_1), .out_item_2(kern_item_2),
        .out_item_3(kern_item_3), .out_item_4(kern_item_4)
    );

    stream_fifo #(.item_t(out_item_t)) out_q_1 (
        .clk, .reset, .push(out_push[0]), .push_item(kern_item_1), .full(out_full[0]),
        .pop(out_pop[0]), .pop_item(enc_item_1), .empty(out_empty[0])
    );

    stream_fifo #(.item_t(out_item_t)) out_q_2 (
        .clk, .reset, .push(out_push[1]), .push_item(kern_item_2), .full(out_full[1]),
        .pop(out_pop[1]), .pop_item(enc_item_2), .empty(out_empty[1])
    );

    stream_fifo #(.item_t(out_item_t)) out_q_3 (
        .clk, .reset, .push(out_push[2]), .push_item(kern_item_3), .full(out_full[2]),
        .pop(out_pop[2]), .pop_item(enc_item_3), .empty(out_empty[2])
    );

    stream_fifo #(.item_t(out_item_t)) out_q_4 (
        .clk, .reset, .push(out_push[3]), .push_item(kern_item_4), .full(out_full[3]),
        .pop(out_pop[3]), .pop_item(enc_item_4), .empty(out_empty[3])
    );

    // ##############################
    // result
    // ##############################
    packet_encoder result (
        .clk, .reset, .resend, .empty(out_empty),
        .item_1(enc_item_1), .item_2(enc_item_2), .item_3(enc_item_3), .item_4(enc_item_4),
        .pop(out_pop), .dest_1, .dest_2, .dest_3, .dest_4,
        .dout(dout_leaf_interface2bft)    // blanked during resend
    );

endmodule

// File: verilog/packet_decoder.sv
module packet_decoder import bft_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  bft_packet_t          din,
    input  logic [leaf_bits-1:0] leaf_id,
    output logic                 push,
    output payload_t             push_item,
    input  logic                 full,
    output logic                 drop,
    output logic                 misroute
);

    logic                 vld_q;
    logic [leaf_bits-1:0] leaf_q;
    logic [port_bits-1:0] port_q;
    payload_t             payload_q;
    logic                 addr_ok;

    // ##############################
    // input register
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= din.valid;
        end
    end

    always_ff @(posedge clk) begin
        leaf_q    <= din.leaf;
        port_q    <= din.port;
        payload_q <= din.payload;    // addr field unused on this leaf
    end

    // ##############################
    // accept, drop or misroute
    // ##############################
    assign addr_ok = (leaf_q == leaf_id) && (port_q == port_bits'(in_port_id));

    assign push      = vld_q && addr_ok && !full;
    assign push_item = payload_q;
    assign drop      = vld_q && addr_ok && full;    // queue full, word lost
    assign misroute  = vld_q && !addr_ok;

endmodule

// File: verilog/packet_encoder.sv
module packet_encoder import bft_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           resend,
    input  logic [num_out_ports-1:0]       empty,
    input  out_item_t                      item_1,
    input  out_item_t                      item_2,
    input  out_item_t                      item_3,
    input  out_item_t                      item_4,
    output logic [num_out_ports-1:0]       pop,
    input  logic [leaf_bits+port_bits-1:0] dest_1,
    input  logic [leaf_bits+port_bits-1:0] dest_2,
    input  logic [leaf_bits+port_bits-1:0] dest_3,
    input  logic [leaf_bits+port_bits-1:0] dest_4,
    output bft_packet_t                    dout
);

    localparam int sel_bits = $clog2(num_out_ports);

    out_item_t                      item_arr [num_out_ports];
    logic [leaf_bits+port_bits-1:0] dest_arr [num_out_ports];
    logic [sel_bits-1:0]            last_q;
    logic [sel_bits-1:0]            cand;
    logic [sel_bits-1:0]            grant;
    logic                           found;
    logic                           send;
    bft_packet_t                    pkt_q;

    assign item_arr = '{item_1, item_2, item_3, item_4};
    assign dest_arr = '{dest_1, dest_2, dest_3, dest_4};

    // ##############################
    // round robin arbiter
    // ##############################
    always_comb begin
        grant = last_q;
        found = 1'b0;
        cand  = last_q;
        for (int i = 1; i <= num_out_ports; i++) begin
            cand = last_q + sel_bits'(i);    // search starts after last served
            if (!found && !empty[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
    end

    assign send = found && !resend;
    assign pop  = send ? (num_out_ports'(1) << grant) : '0;

    // ##############################
    // packet register
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_q  <= '0;
            last_q <= '0;
        end else if (send) begin
            pkt_q.valid   <= 1'b1;
            pkt_q.leaf    <= dest_arr[grant][leaf_bits+port_bits-1 -: leaf_bits];
            pkt_q.port    <= dest_arr[grant][port_bits-1:0];
            pkt_q.addr    <= item_arr[grant].addr;
            pkt_q.payload <= item_arr[grant].payload;
            last_q        <= grant;
        end else if (!resend) begin
            pkt_q <= '0;    // idle
        end
        // during resend the pending packet is held and shows once resend drops
    end

    assign dout = resend ? '0 : pkt_q;

endmodule

// File: verilog/stream_fifo.sv
module stream_fifo import bft_pkg::*; #(
    parameter type item_t = payload_t,
    parameter int  depth  = queue_depth
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_item,
    output logic  full,
    input  logic  pop,
    output item_t pop_item,
    output logic  empty
);

    localparam int ptr_bits = $clog2(depth);

    item_t               mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == (ptr_bits+1)'(depth));
    assign empty    = (count == '0);
    assign pop_item = mem[rd_ptr];    // head is visible before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/user_kernel.sv
module user_kernel import bft_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     enable,
    input  logic                     in_empty,
    input  payload_t                 in_item,
    output logic                     in_pop,
    input  logic [num_out_ports-1:0] out_full,
    output logic [num_out_ports-1:0] out_push,
    output out_item_t                out_item_1,
    output out_item_t                out_item_2,
    output out_item_t                out_item_3,
    output out_item_t                out_item_4
);

    logic                 fire;
    payload_t             sum_q;
    payload_t             sum_next;
    logic [addr_bits-1:0] idx_q;

    // one word per cycle, only when every output has room
    assign fire = enable && !in_empty && !(|out_full);

    assign in_pop   = fire;
    assign out_push = {num_out_ports{fire}};

    assign sum_next = sum_q + in_item;    // mod 2^32

    // ##############################
    // result words
    // ##############################
    always_comb begin
        out_item_1.addr    = idx_q;
        out_item_1.payload = in_item;
        out_item_2.addr    = idx_q;
        out_item_2.payload = {in_item[payload_bits-2:0], 1'b0};
        out_item_3.addr    = idx_q;
        out_item_3.payload = ~in_item;
        out_item_4.addr    = idx_q;
        out_item_4.payload = sum_next;    // includes the current word
    end

    // ##############################
    // kernel state
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_q <= '0;
            idx_q <= '0;
        end else if (fire) begin
            sum_q <= sum_next;
            idx_q <= idx_q + 1'b1;    // wraps at 128
        end
    end

endmodule
